// ==== common/axis_sw_macros.svh ====
`ifndef AXIS_SW_MACROS_SVH
`define AXIS_SW_MACROS_SVH

// stream payload widths
`define AXIS_DATA_WIDTH 32
`define AXIS_USER_WIDTH 2
`define AXIS_TID_WIDTH 2

// upstream sources: user project, axi-lite bridge, logic analyzer
`define AXIS_NUM_SRC 3

// receive side
`define RX_FIFO_DEPTH 16
`define TH_RESET 6

// reduced axi-lite write path
`define AXIL_ADDR_WIDTH 15

`endif

// ==== common/axis_sw_pkg.sv ====
`include "axis_sw_macros.svh"

package axis_sw_pkg;

  // one stream beat without routing information
  typedef struct packed {
    logic [`AXIS_DATA_WIDTH-1:0]   data;
    logic [`AXIS_DATA_WIDTH/8-1:0] strb;
    logic [`AXIS_DATA_WIDTH/8-1:0] keep;
    logic                          last;
    logic [`AXIS_USER_WIDTH-1:0]   user;
  } axis_beat_t;

  // source index upstream, destination index downstream
  typedef logic [`AXIS_TID_WIDTH-1:0] axis_tid_t;

  // beat on the serializer link, also one rx fifo entry
  typedef struct packed {
    axis_beat_t beat;
    axis_tid_t  tid;
  } axis_tagged_beat_t;

  // write address and data fields, sampled together
  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0]   awaddr;
    logic [`AXIS_DATA_WIDTH-1:0]   wdata;
    logic [`AXIS_DATA_WIDTH/8-1:0] wstrb;
  } axil_wr_t;

  // rx fifo fill threshold
  typedef logic [3:0] th_t;

endpackage

// ==== arbiter/axis_rr_arbiter.sv ====
`include "axis_sw_macros.svh"

module axis_rr_arbiter (
  input  logic                     axis_clk,
  input  logic                     axi_reset_n,
  input  logic [`AXIS_NUM_SRC-1:0] req,
  input  logic                     frame_done,
  output logic [`AXIS_NUM_SRC-1:0] grant
);

  localparam int N = `AXIS_NUM_SRC;
  localparam int PTR_W = $clog2(N);

  logic [PTR_W-1:0] base_ptr;
  logic [PTR_W-1:0] served;
  logic [PTR_W-1:0] next_ptr;
  logic [N-1:0]     pick;

  // first requester at or after base_ptr, wrapping around
  always_comb begin
    int  idx;
    logic found;
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < N; i++) begin
      idx = (int'(base_ptr) + i) % N;
      if (!found && req[idx]) begin
        pick[idx] = 1'b1;
        found     = 1'b1;
      end
    end
  end

  // index of the source currently holding the grant
  always_comb begin
    served = '0;
    for (int i = 0; i < N; i++) begin
      if (grant[i]) begin
        served = PTR_W'(i);
      end
    end
  end

  assign next_ptr = (served == PTR_W'(N - 1)) ? '0 : served + 1'b1;

  ////////////////////
  // grant register

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      grant    <= '0;
      base_ptr <= '0;
    end else if (grant == '0) begin
      grant <= pick;
    end else if (frame_done) begin
      // one idle cycle before the next pick
      grant    <= '0;
      base_ptr <= next_ptr;
    end
  end

endmodule

// ==== arbiter/axis_upstream_mux.sv ====
`include "axis_sw_macros.svh"

module axis_upstream_mux (
  input  logic                          axis_clk,
  input  logic                          axi_reset_n,
  input  axis_sw_pkg::axis_beat_t       up_as_beat,
  input  logic                          up_as_tvalid,
  input  axis_sw_pkg::axis_beat_t       aa_as_beat,
  input  logic                          aa_as_tvalid,
  input  axis_sw_pkg::axis_beat_t       la_as_beat,
  input  logic                          la_as_tvalid,
  input  logic                          is_as_tready,
  output logic                          as_up_tready,
  output logic                          as_aa_tready,
  output logic                          as_la_tready,
  output axis_sw_pkg::axis_tagged_beat_t as_is_beat,
  output logic                          as_is_tvalid
);

  import axis_sw_pkg::*;

  localparam int N = `AXIS_NUM_SRC;

  axis_beat_t   src_beat [N];
  logic [N-1:0] src_valid;
  logic [N-1:0] src_ready;
  logic [N-1:0] grant;
  axis_beat_t   sel_beat;
  axis_tid_t    sel_tid;
  logic         out_free;
  logic         accept;
  logic         frame_done;

  assign src_beat[0] = up_as_beat;
  assign src_beat[1] = aa_as_beat;
  assign src_beat[2] = la_as_beat;
  assign src_valid   = {la_as_tvalid, aa_as_tvalid, up_as_tvalid};

  axis_rr_arbiter arbiter_i (
    .axis_clk    (axis_clk),
    .axi_reset_n (axi_reset_n),
    .req         (src_valid),
    .frame_done  (frame_done),
    .grant       (grant)
  );

  // granted source onto the output stage, tagged with its index
  always_comb begin
    sel_beat = '0;
    sel_tid  = '0;
    for (int i = 0; i < N; i++) begin
      if (grant[i]) begin
        sel_beat = src_beat[i];
        sel_tid  = axis_tid_t'(i);
      end
    end
  end

  // output register can take a new beat when empty or draining
  assign out_free  = !as_is_tvalid || is_as_tready;
  assign src_ready = grant & {N{out_free}};
  assign accept    = |(src_valid & src_ready);
  assign frame_done = accept && sel_beat.last;

  assign as_up_tready = src_ready[0];
  assign as_aa_tready = src_ready[1];
  assign as_la_tready = src_ready[2];

  ////////////////////
  // output stage

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      as_is_tvalid <= 1'b0;
    end else if (out_free) begin
      as_is_tvalid <= accept;
    end
  end

  always_ff @(posedge axis_clk) begin
    if (accept) begin
      as_is_beat <= '{beat: sel_beat, tid: sel_tid};
    end
  end

endmodule

// ==== demux/axis_rx_fifo.sv ====
`include "axis_sw_macros.svh"

module axis_rx_fifo (
  input  logic                           axis_clk,
  input  logic                           axi_reset_n,
  input  axis_sw_pkg::axis_tagged_beat_t is_as_beat,
  input  logic                           is_as_tvalid,
  input  axis_sw_pkg::th_t               threshold,
  input  logic                           pop,
  output logic                           as_is_tready,
  output axis_sw_pkg::axis_tagged_beat_t head,
  output logic                           empty
);

  import axis_sw_pkg::*;

  localparam int DEPTH = `RX_FIFO_DEPTH;
  localparam int AW = $clog2(DEPTH);

  axis_tagged_beat_t mem [DEPTH];

  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] wr_ptr_next;
  logic [AW:0] rd_ptr_next;
  logic [AW:0] count_next;
  logic        wr_en;
  logic        rd_en;

  assign wr_en = is_as_tvalid && as_is_tready;
  assign rd_en = pop && !empty;

  assign empty = (wr_ptr == rd_ptr);
  assign head  = mem[rd_ptr[AW-1:0]];

  assign wr_ptr_next = wr_ptr + (AW + 1)'(wr_en);
  assign rd_ptr_next = rd_ptr + (AW + 1)'(rd_en);

  // occupancy once this cycle's push and pop have landed
  assign count_next = wr_ptr_next - rd_ptr_next;

  ////////////////////
  // pointers and tready

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      as_is_tready <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr_next;
      rd_ptr <= rd_ptr_next;
      // keep two entries spare for the beat in flight behind tready
      as_is_tready <= (count_next <= {1'b0, threshold}) &&
                      (count_next <= (AW + 1)'(DEPTH - 2));
    end
  end

  // storage
  always_ff @(posedge axis_clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= is_as_beat;
    end
  end

endmodule

// ==== demux/axis_downstream_demux.sv ====
module axis_downstream_demux (
  input  axis_sw_pkg::axis_tagged_beat_t head,
  input  logic                           empty,
  input  logic                           up_as_tready,
  input  logic                           aa_as_tready,
  output axis_sw_pkg::axis_beat_t        as_up_beat,
  output logic                           as_up_tvalid,
  output axis_sw_pkg::axis_beat_t        as_aa_beat,
  output logic                           as_aa_tvalid,
  output logic                           pop
);

  import axis_sw_pkg::*;

  localparam axis_tid_t TID_UP = 2'd0;
  localparam axis_tid_t TID_AA = 2'd1;

  logic to_up;
  logic to_aa;
  logic drop;

  // tid decode of the fifo head
  assign to_up = !empty && (head.tid == TID_UP);
  assign to_aa = !empty && (head.tid == TID_AA);
  // tid 2 and 3 have no sink
  assign drop  = !empty && !to_up && !to_aa;

  assign as_up_tvalid = to_up;
  assign as_aa_tvalid = to_aa;

  // sinks see zeros unless they are addressed
  assign as_up_beat = to_up ? head.beat : '0;
  assign as_aa_beat = to_aa ? head.beat : '0;

  ////////////////////
  // pop

  // unrouted entries go one per cycle without a handshake
  assign pop = (to_up && up_as_tready) ||
               (to_aa && aa_as_tready) ||
               drop;

endmodule

// ==== verilog/axis_sw_config.sv ====
`include "axis_sw_macros.svh"

module axis_sw_config (
  input  logic                        axis_clk,
  input  logic                        axi_reset_n,
  input  logic                        cc_as_enable,
  input  logic                        axi_awvalid,
  input  logic                        axi_wvalid,
  input  axis_sw_pkg::axil_wr_t       axi_wr,
  output logic                        axi_awready,
  output logic                        axi_wready,
  output logic [`AXIS_DATA_WIDTH-1:0] axi_rdata,
  output axis_sw_pkg::th_t            threshold
);

  import axis_sw_pkg::*;

  logic wr_fire;
  logic hit_th;

  // address and data are taken together, only while enabled
  assign wr_fire     = cc_as_enable && axi_awvalid && axi_wvalid;
  assign axi_awready = wr_fire;
  assign axi_wready  = wr_fire;

  // word offset 0, low byte lane
  assign hit_th = (axi_wr.awaddr[11:2] == '0) && axi_wr.wstrb[0];

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      threshold <= th_t'(`TH_RESET);
    end else if (wr_fire && hit_th) begin
      threshold <= axi_wr.wdata[3:0];
    end
  end

  // single readable register, no read handshake
  assign axi_rdata = `AXIS_DATA_WIDTH'(threshold);

endmodule

// ==== verilog/axis_sw.sv ====
`include "axis_sw_macros.svh"

module axis_sw (
  input  logic                           axis_clk,
  input  logic                           axi_reset_n,
  input  logic                           cc_as_enable,
  input  logic                           axi_awvalid,
  input  logic                           axi_wvalid,
  input  axis_sw_pkg::axil_wr_t          axi_wr,
  input  axis_sw_pkg::axis_beat_t        up_as_beat,
  input  axis_sw_pkg::axis_beat_t        aa_as_beat,
  input  axis_sw_pkg::axis_beat_t        la_as_beat,
  input  logic                           up_as_tvalid,
  input  logic                           aa_as_tvalid,
  input  logic                           la_as_tvalid,
  input  logic                           is_as_tready,
  input  axis_sw_pkg::axis_tagged_beat_t is_as_beat,
  input  logic                           is_as_tvalid,
  input  logic                           up_as_tready,
  input  logic                           aa_as_tready,
  output logic                           axi_awready,
  output logic                           axi_wready,
  output logic [`AXIS_DATA_WIDTH-1:0]    axi_rdata,
  output logic                           as_up_tready,
  output logic                           as_aa_tready,
  output logic                           as_la_tready,
  output axis_sw_pkg::axis_tagged_beat_t as_is_beat,
  output logic                           as_is_tvalid,
  output logic                           as_is_tready,
  output axis_sw_pkg::axis_beat_t        as_up_beat,
  output axis_sw_pkg::axis_beat_t        as_aa_beat,
  output logic                           as_up_tvalid,
  output logic                           as_aa_tvalid
);

  import axis_sw_pkg::*;

  th_t               threshold;
  axis_tagged_beat_t head;
  logic              empty;
  logic              pop;

  ////////////////////
  // configuration

  axis_sw_config config_i (
    .axis_clk     (axis_clk),
    .axi_reset_n  (axi_reset_n),
    .cc_as_enable (cc_as_enable),
    .axi_awvalid  (axi_awvalid),
    .axi_wvalid   (axi_wvalid),
    .axi_wr       (axi_wr),
    .axi_awready  (axi_awready),
    .axi_wready   (axi_wready),
    .axi_rdata    (axi_rdata),
    .threshold    (threshold)
  );

  ////////////////////
  // upstream toward the serializer

  axis_upstream_mux upstream_i (
    .axis_clk     (axis_clk),
    .axi_reset_n  (axi_reset_n),
    .up_as_beat   (up_as_beat),
    .up_as_tvalid (up_as_tvalid),
    .aa_as_beat   (aa_as_beat),
    .aa_as_tvalid (aa_as_tvalid),
    .la_as_beat   (la_as_beat),
    .la_as_tvalid (la_as_tvalid),
    .is_as_tready (is_as_tready),
    .as_up_tready (as_up_tready),
    .as_aa_tready (as_aa_tready),
    .as_la_tready (as_la_tready),
    .as_is_beat   (as_is_beat),
    .as_is_tvalid (as_is_tvalid)
  );

  ////////////////////
  // downstream from the serializer

  axis_rx_fifo rx_fifo_i (
    .axis_clk     (axis_clk),
    .axi_reset_n  (axi_reset_n),
    .is_as_beat   (is_as_beat),
    .is_as_tvalid (is_as_tvalid),
    .threshold    (threshold),
    .pop          (pop),
    .as_is_tready (as_is_tready),
    .head         (head),
    .empty        (empty)
  );

  axis_downstream_demux demux_i (
    .head         (head),
    .empty        (empty),
    .up_as_tready (up_as_tready),
    .aa_as_tready (aa_as_tready),
    .as_up_beat   (as_up_beat),
    .as_up_tvalid (as_up_tvalid),
    .as_aa_beat   (as_aa_beat),
    .as_aa_tvalid (as_aa_tvalid),
    .pop          (pop)
  );

endmodule

// ==== tests/axis_sw_properties.sv ====
module axis_sw_properties (
  input logic                           axis_clk,
  input logic                           axi_reset_n,
  input axis_sw_pkg::axis_tagged_beat_t as_is_beat,
  input logic                           as_is_tvalid,
  input logic                           is_as_tready,
  input logic                           as_up_tvalid,
  input logic                           as_aa_tvalid
);

  timeunit 1ns;
  timeprecision 100ps;

  // stalled serializer beat must not move
  beat_held_a: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
    as_is_tvalid && !is_as_tready |=> as_is_tvalid && $stable(as_is_beat))
    else $error("as_is beat changed or dropped while stalled");

  // one sink at a time
  sinks_exclusive_a: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
    !(as_up_tvalid && as_aa_tvalid))
    else $error("as_up and as_aa valid in the same cycle");

  // only sources 0 to 2 exist upstream
  tid_range_a: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
    as_is_tvalid |-> as_is_beat.tid != 2'd3)
    else $error("as_is carries tid 3");

endmodule

bind axis_sw axis_sw_properties props_i (
  .axis_clk     (axis_clk),
  .axi_reset_n  (axi_reset_n),
  .as_is_beat   (as_is_beat),
  .as_is_tvalid (as_is_tvalid),
  .is_as_tready (is_as_tready),
  .as_up_tvalid (as_up_tvalid),
  .as_aa_tvalid (as_aa_tvalid)
);

// ==== tests/axis_sw_tb.sv ====
`include "axis_sw_macros.svh"

module axis_sw_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import axis_sw_pkg::*;

  localparam int TIMEOUT = 2000;

  logic                        axis_clk;
  logic                        axi_reset_n;
  logic                        cc_as_enable;
  logic                        axi_awvalid;
  logic                        axi_wvalid;
  axil_wr_t                    axi_wr;
  logic                        axi_awready;
  logic                        axi_wready;
  logic [`AXIS_DATA_WIDTH-1:0] axi_rdata;
  axis_beat_t                  src_beat [3];
  logic [2:0]                  src_valid;
  logic [2:0]                  src_ready;
  logic                        is_as_tready;
  axis_tagged_beat_t           is_as_beat;
  logic                        is_as_tvalid;
  logic                        up_as_tready;
  logic                        aa_as_tready;
  axis_tagged_beat_t           as_is_beat;
  logic                        as_is_tvalid;
  logic                        as_is_tready;
  axis_beat_t                  as_up_beat;
  axis_beat_t                  as_aa_beat;
  logic                        as_up_tvalid;
  logic                        as_aa_tvalid;

  // stimulus and expected streams
  axis_beat_t        stim [3][8];
  axis_tagged_beat_t rx_stim [24];
  axis_tagged_beat_t exp_q [$];
  axis_beat_t        up_q [$];
  axis_beat_t        aa_q [$];
  int                mismatches = 0;
  int                failures = 0;

  axis_sw axis_sw_i (
    .up_as_beat   (src_beat[0]),
    .aa_as_beat   (src_beat[1]),
    .la_as_beat   (src_beat[2]),
    .up_as_tvalid (src_valid[0]),
    .aa_as_tvalid (src_valid[1]),
    .la_as_tvalid (src_valid[2]),
    .as_up_tready (src_ready[0]),
    .as_aa_tready (src_ready[1]),
    .as_la_tready (src_ready[2]),
    .*
  );

  initial begin
    axis_clk = 1'b0;
    forever #50 axis_clk = ~axis_clk;
  end

  ////////////////////
  // checks

  task automatic compare_beat(input string name, input axis_beat_t got, input axis_beat_t want);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
      mismatches++;
    end
  endtask

  task automatic compare_tagged(input string name, input axis_tagged_beat_t got,
                                input axis_tagged_beat_t want);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
      mismatches++;
    end
  endtask

  task automatic compare_th(input string name, input th_t got, input th_t want);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want);
      mismatches++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    failures++;
  endtask

  ////////////////////
  // stimulus helpers

  function automatic axis_beat_t make_beat(input logic last);
    logic [63:0] r;
    axis_beat_t  b;
    r = {$urandom, $urandom};
    b = r[$bits(axis_beat_t)-1:0];
    b.last = last;
    return b;
  endfunction

  function automatic axis_tagged_beat_t tag_beat(input axis_beat_t b, input int tid);
    axis_tagged_beat_t t;
    t.beat = b;
    t.tid = axis_tid_t'(tid);
    return t;
  endfunction

  task automatic apply_reset();
    axi_reset_n = 1'b0;
    repeat (5) @(negedge axis_clk);
    axi_reset_n = 1'b1;
  endtask

  task automatic write_cfg(input logic en, input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data, input logic [3:0] strb);
    @(negedge axis_clk);
    cc_as_enable = en;
    axi_awvalid = 1'b1;
    axi_wvalid = 1'b1;
    axi_wr = '{awaddr: addr, wdata: data, wstrb: strb};
    @(posedge axis_clk);
    // both channels accept together, only while enabled
    compare_flag("axi_awready", axi_awready, en);
    compare_flag("axi_wready", axi_wready, en);
    @(negedge axis_clk);
    axi_awvalid = 1'b0;
    axi_wvalid = 1'b0;
    cc_as_enable = 1'b1;
  endtask

  // one source, n beats from stim, each held until taken
  task automatic send_beats(input int src, input int n);
    int wait_cnt;
    for (int i = 0; i < n; i++) begin
      @(negedge axis_clk);
      src_beat[src] = stim[src][i];
      src_valid[src] = 1'b1;
      wait_cnt = 0;
      do begin
        @(posedge axis_clk);
        wait_cnt++;
      end while (!src_ready[src] && wait_cnt < TIMEOUT);
      if (!src_ready[src]) begin
        report_failure($sformatf("source %0d tready never came", src));
        break;
      end
    end
    @(negedge axis_clk);
    src_valid[src] = 1'b0;
  endtask

  task automatic send_rx(input int n);
    int wait_cnt;
    for (int i = 0; i < n; i++) begin
      @(negedge axis_clk);
      is_as_beat = rx_stim[i];
      is_as_tvalid = 1'b1;
      wait_cnt = 0;
      do begin
        @(posedge axis_clk);
        wait_cnt++;
      end while (!as_is_tready && wait_cnt < TIMEOUT);
      if (!as_is_tready) begin
        report_failure("as_is_tready stayed low while sending");
        break;
      end
    end
    @(negedge axis_clk);
    is_as_tvalid = 1'b0;
  endtask

  // serializer side, random ready
  task automatic collect_as_is(input int n);
    int got;
    int idle;
    got = 0;
    idle = 0;
    while (got < n && idle < TIMEOUT) begin
      @(negedge axis_clk);
      is_as_tready = 1'($urandom_range(1, 0));
      @(posedge axis_clk);
      idle++;
      if (as_is_tvalid && is_as_tready) begin
        got++;
        idle = 0;
        if (exp_q.size() == 0)
          report_failure("unexpected beat on as_is");
        else
          compare_tagged("as_is_beat", as_is_beat, exp_q.pop_front());
      end
    end
    if (got < n)
      report_failure($sformatf("timed out with %0d of %0d as_is beats", got, n));
    @(negedge axis_clk);
    is_as_tready = 1'b1;
  endtask

  task automatic collect_downstream(input int n_up, input int n_aa, input bit rand_ready);
    int got_up;
    int got_aa;
    int idle;
    got_up = 0;
    got_aa = 0;
    idle = 0;
    while ((got_up < n_up || got_aa < n_aa) && idle < TIMEOUT) begin
      @(negedge axis_clk);
      up_as_tready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
      aa_as_tready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
      @(posedge axis_clk);
      idle++;
      if (as_up_tvalid && up_as_tready) begin
        got_up++;
        idle = 0;
        if (up_q.size() == 0)
          report_failure("unexpected beat on as_up");
        else
          compare_beat("as_up_beat", as_up_beat, up_q.pop_front());
      end
      if (as_aa_tvalid && aa_as_tready) begin
        got_aa++;
        idle = 0;
        if (aa_q.size() == 0)
          report_failure("unexpected beat on as_aa");
        else
          compare_beat("as_aa_beat", as_aa_beat, aa_q.pop_front());
      end
    end
    if (got_up < n_up || got_aa < n_aa)
      report_failure("timed out waiting for downstream beats");
  endtask

  ////////////////////
  // tests

  task automatic test_config();
    compare_th("axi_rdata", th_t'(axi_rdata[3:0]), th_t'(`TH_RESET));
    write_cfg(1'b1, 15'h0, 32'd9, 4'h1);
    compare_th("axi_rdata", th_t'(axi_rdata[3:0]), th_t'(9));
    // disabled, wrong offset, low lane off
    write_cfg(1'b0, 15'h0, 32'd5, 4'h1);
    compare_th("axi_rdata", th_t'(axi_rdata[3:0]), th_t'(9));
    write_cfg(1'b1, 15'h4, 32'd5, 4'h1);
    compare_th("axi_rdata", th_t'(axi_rdata[3:0]), th_t'(9));
    write_cfg(1'b1, 15'h0, 32'd5, 4'he);
    compare_th("axi_rdata", th_t'(axi_rdata[3:0]), th_t'(9));
  endtask

  task automatic test_single_source();
    int len;
    for (int s = 0; s < 3; s++) begin
      len = $urandom_range(8, 1);
      for (int i = 0; i < len; i++) begin
        stim[s][i] = make_beat(i == len - 1);
        exp_q.push_back(tag_beat(stim[s][i], s));
      end
      fork
        send_beats(s, len);
        collect_as_is(len);
      join
    end
  endtask

  // two 2-beat frames per source, all requesting at once
  task automatic test_fairness();
    apply_reset();
    for (int s = 0; s < 3; s++) begin
      for (int i = 0; i < 4; i++)
        stim[s][i] = make_beat(i % 2 == 1);
    end
    for (int f = 0; f < 2; f++) begin
      for (int s = 0; s < 3; s++) begin
        exp_q.push_back(tag_beat(stim[s][2 * f], s));
        exp_q.push_back(tag_beat(stim[s][2 * f + 1], s));
      end
    end
    fork
      send_beats(0, 4);
      send_beats(1, 4);
      send_beats(2, 4);
      collect_as_is(12);
    join
  endtask

  task automatic test_routing();
    int n_up;
    int n_aa;
    n_up = 0;
    n_aa = 0;
    for (int i = 0; i < 24; i++) begin
      rx_stim[i] = tag_beat(make_beat(1'($urandom_range(1, 0))), $urandom_range(3, 0));
      if (rx_stim[i].tid == 0) begin
        up_q.push_back(rx_stim[i].beat);
        n_up++;
      end else if (rx_stim[i].tid == 1) begin
        aa_q.push_back(rx_stim[i].beat);
        n_aa++;
      end
    end
    fork
      send_rx(24);
      collect_downstream(n_up, n_aa, 1'b1);
    join
  endtask

  task automatic test_backpressure();
    axis_tagged_beat_t cur;
    int                accepted;
    accepted = 0;
    @(negedge axis_clk);
    up_as_tready = 1'b0;
    write_cfg(1'b1, 15'h0, 32'd3, 4'h1);
    compare_th("axi_rdata", th_t'(axi_rdata[3:0]), th_t'(3));
    cur = tag_beat(make_beat(1'b0), 0);
    // sink stalled, keep offering for a fixed window
    repeat (2 * `RX_FIFO_DEPTH) begin
      @(negedge axis_clk);
      is_as_beat = cur;
      is_as_tvalid = 1'b1;
      @(posedge axis_clk);
      if (as_is_tready) begin
        up_q.push_back(cur.beat);
        accepted++;
        cur = tag_beat(make_beat(1'($urandom_range(1, 0))), 0);
      end
    end
    @(negedge axis_clk);
    is_as_tvalid = 1'b0;
    if (as_is_tready)
      report_failure("as_is_tready did not fall under back-pressure");
    if (accepted < 4 || accepted > `RX_FIFO_DEPTH)
      report_failure($sformatf("%0d beats accepted with threshold 3", accepted));
    collect_downstream(accepted, 0, 1'b0);
    write_cfg(1'b1, 15'h0, `TH_RESET, 4'h1);
  endtask

  ////////////////////
  // main sequence

  initial begin
    void'($urandom(32'h16d));
    axi_reset_n = 1'b0;
    cc_as_enable = 1'b1;
    axi_awvalid = 1'b0;
    axi_wvalid = 1'b0;
    axi_wr = '0;
    foreach (src_beat[i])
      src_beat[i] = '0;
    src_valid = '0;
    is_as_tready = 1'b1;
    is_as_beat = '0;
    is_as_tvalid = 1'b0;
    up_as_tready = 1'b1;
    aa_as_tready = 1'b1;
    apply_reset();
    test_config();
    test_single_source();
    test_fairness();
    test_routing();
    test_backpressure();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+common
common/axis_sw_pkg.sv
arbiter/axis_rr_arbiter.sv
arbiter/axis_upstream_mux.sv
demux/axis_rx_fifo.sv
demux/axis_downstream_demux.sv
verilog/axis_sw_config.sv
verilog/axis_sw.sv
tests/axis_sw_properties.sv
tests/axis_sw_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module axis_sw_tb -o axis_sw_sim > build.log 2>&1 &&
  ./obj_dir/axis_sw_sim > sim.log 2>&1
grep -q "Regression passed" sim.log && echo "simulation ok" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }
